//--- rtl/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Datapath word
`define DATA_WIDTH 32

`define REG_ADDR_WIDTH 5

// 64 data memory words
`define DMEM_ADDR_WIDTH 6

`endif

//--- rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE  = 6'b000000, // ALU ops picked by funct
        OP_REGIMM = 6'b000001, // BGEZ or BLTZ, rt bit 0 decides
        OP_J      = 6'b000010,
        OP_JAL    = 6'b000011, // Not supported here
        OP_BEQ    = 6'b000100,
        OP_BNE    = 6'b000101,
        OP_BLEZ   = 6'b000110,
        OP_BGTZ   = 6'b000111,
        OP_ADDI   = 6'b001000,
        OP_ADDIU  = 6'b001001,
        OP_SLTI   = 6'b001010,
        OP_SLTIU  = 6'b001011,
        OP_ANDI   = 6'b001100,
        OP_ORI    = 6'b001101,
        OP_XORI   = 6'b001110,
        OP_LUI    = 6'b001111, // Not supported here
        OP_LB     = 6'b100000, // Byte and halfword access unsupported
        OP_LH     = 6'b100001,
        OP_LW     = 6'b100011,
        OP_SB     = 6'b101000,
        OP_SH     = 6'b101001,
        OP_SW     = 6'b101011
    } opcodeT;

    // Compare ops only drive condTrue in the ALU
    typedef enum logic [4:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL,
        ALU_EQ, ALU_NE, ALU_LEZ, ALU_GTZ, ALU_GEZ, ALU_LTZ,
        ALU_FUNCT // Resolved from funct by AluController
    } aluOpT;

    typedef enum logic [1:0] {DST_RD, DST_RT} regDstT;

    typedef enum logic [1:0] {WB_ALU, WB_MEM} memToRegT;

endpackage

`default_nettype wire

//--- rtl/DatapathController.sv
`timescale 1ns/1ps
`default_nettype none

module DatapathController import mips_pkg::*; (
    input  wire opcodeT   opCode,
    output regDstT        regDst,
    output logic          regWrite,
    output logic          aluSrc,
    output logic          memWrite,
    output logic          memRead,
    output logic          branch,
    output memToRegT      memToReg,
    output logic          signExt,
    output logic          jump,
    output aluOpT         aluClass
);

    always_comb begin
        regDst   = DST_RT; // Idle values, same as an unsupported opcode
        regWrite = 1'b0;
        aluSrc   = 1'b0;
        memWrite = 1'b0;
        memRead  = 1'b0;
        branch   = 1'b0;
        memToReg = WB_ALU;
        signExt  = 1'b0;
        jump     = 1'b0;
        aluClass = ALU_ADDU;

        case (opCode)
            OP_RTYPE: begin
                regDst   = DST_RD;
                regWrite = 1'b1;
                aluClass = ALU_FUNCT; // Refined from funct
            end
            OP_REGIMM: begin
                branch   = 1'b1;
                aluClass = ALU_GEZ; // Top flips to LTZ from rt
            end
            OP_J: begin
                jump = 1'b1;
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                branch = 1'b1;
                case (opCode)
                    OP_BEQ:  aluClass = ALU_EQ;
                    OP_BNE:  aluClass = ALU_NE;
                    OP_BLEZ: aluClass = ALU_LEZ;
                    default: aluClass = ALU_GTZ;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                signExt  = 1'b1;
                case (opCode)
                    OP_ADDI:  aluClass = ALU_ADD;
                    OP_ADDIU: aluClass = ALU_ADDU;
                    OP_SLTI:  aluClass = ALU_SLT;
                    default:  aluClass = ALU_SLTU; // Sign extended, unsigned compare
                endcase
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1; // Zero extended immediate
                case (opCode)
                    OP_ANDI: aluClass = ALU_AND;
                    OP_ORI:  aluClass = ALU_OR;
                    default: aluClass = ALU_XOR;
                endcase
            end
            OP_LW: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                memRead  = 1'b1;
                memToReg = WB_MEM;
                signExt  = 1'b1;
                aluClass = ALU_ADD; // Base plus offset
            end
            OP_SW: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                signExt  = 1'b1;
                aluClass = ALU_ADD;
            end
            default: ; // JAL, LUI, byte/half access keep idle values
        endcase

        // A single instruction never both writes a register and stores
        assert (!(regWrite && memWrite))
            else $error("regWrite and memWrite both high for opcode %0h", opCode);
    end

endmodule

`default_nettype wire

//--- rtl/AluController.sv
`timescale 1ns/1ps
`default_nettype none

module AluController import mips_pkg::*; (
    input  wire aluOpT      aluClass,
    input  wire logic [5:0] funct,
    output aluOpT           aluOp
);

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    always_comb begin
        aluOp = aluClass; // Non R-type passes straight through
        if (aluClass == ALU_FUNCT) begin
            case (funct)
                FN_SLL:  aluOp = ALU_SLL;
                FN_SRL:  aluOp = ALU_SRL;
                FN_ADD:  aluOp = ALU_ADD;
                FN_ADDU: aluOp = ALU_ADDU;
                FN_SUB:  aluOp = ALU_SUB;
                FN_AND:  aluOp = ALU_AND;
                FN_OR:   aluOp = ALU_OR;
                FN_XOR:  aluOp = ALU_XOR;
                FN_NOR:  aluOp = ALU_NOR;
                FN_SLT:  aluOp = ALU_SLT;
                FN_SLTU: aluOp = ALU_SLTU;
                default: aluOp = ALU_ADDU; // Unknown funct, rd still written
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/Alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module Alu import mips_pkg::*; (
    input  wire logic [`DATA_WIDTH-1:0] a,
    input  wire logic [`DATA_WIDTH-1:0] b,
    input  wire logic [4:0]             shamt,
    input  wire aluOpT                  aluOp,
    output logic [`DATA_WIDTH-1:0]      result,
    output logic                        condTrue
);

    logic aNeg;
    logic aZero;

    assign aNeg  = a[`DATA_WIDTH-1]; // Sign of a for the zero compares
    assign aZero = (a == '0);

    always_comb begin
        result   = '0;
        condTrue = 1'b0;
        case (aluOp)
            ALU_ADD, ALU_ADDU: result = a + b; // Both wrap, no trap
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            ALU_SLT:  result = {{(`DATA_WIDTH-1){1'b0}}, ($signed(a) < $signed(b))};
            ALU_SLTU: result = {{(`DATA_WIDTH-1){1'b0}}, (a < b)};
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt; // Logical shift
            ALU_EQ:   condTrue = (a == b);
            ALU_NE:   condTrue = (a != b);
            ALU_LEZ:  condTrue = aNeg || aZero;
            ALU_GTZ:  condTrue = !aNeg && !aZero;
            ALU_GEZ:  condTrue = !aNeg;
            ALU_LTZ:  condTrue = aNeg;
            default: begin
                result   = '0; // ALU_FUNCT never reaches here
                condTrue = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/RegisterFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module RegisterFile (
    input  wire logic                       clk,
    input  wire logic                       arstN,
    input  wire logic [`REG_ADDR_WIDTH-1:0] readAddrA,
    input  wire logic [`REG_ADDR_WIDTH-1:0] readAddrB,
    input  wire logic                       writeEn,
    input  wire logic [`REG_ADDR_WIDTH-1:0] writeAddr,
    input  wire logic [`DATA_WIDTH-1:0]     writeData,
    output logic [`DATA_WIDTH-1:0]          readDataA,
    output logic [`DATA_WIDTH-1:0]          readDataB
);

    logic [`DATA_WIDTH-1:0] regs [2**`REG_ADDR_WIDTH];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**`REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData; // r0 writes dropped
        end
    end

    assign readDataA = regs[readAddrA]; // Async reads
    assign readDataB = regs[readAddrB];

    // Holds across every write sequence, not only the one in flight
    r0StaysZero: assert property (@(posedge clk) disable iff (!arstN)
        (regs[0] == '0))
        else $error("register 0 lost its zero value");

endmodule

`default_nettype wire

//--- rtl/DataMemory.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module DataMemory (
    input  wire logic                        clk,
    input  wire logic                        arstN,
    input  wire logic [`DMEM_ADDR_WIDTH-1:0] addr,
    input  wire logic                        writeEn,
    input  wire logic [`DATA_WIDTH-1:0]      writeData,
    output logic [`DATA_WIDTH-1:0]           readData
);

    logic [`DATA_WIDTH-1:0] mem [2**`DMEM_ADDR_WIDTH]; // Word addressed

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**`DMEM_ADDR_WIDTH; i++) begin
                mem[i] <= '0;
            end
        end else if (writeEn) begin
            mem[addr] <= writeData;
        end
    end

    assign readData = mem[addr];

endmodule

`default_nettype wire

//--- rtl/ExecuteCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module ExecuteCore import mips_pkg::*; (
    input  wire logic                        clk,
    input  wire logic                        arstN,
    input  wire logic [31:0]                 instr,
    input  wire logic                        instrValid,
    output logic                             regWriteEn,
    output logic [`REG_ADDR_WIDTH-1:0]       writeReg,
    output logic [`DATA_WIDTH-1:0]           writeData,
    output logic                             memWriteEn,
    output logic [`DMEM_ADDR_WIDTH-1:0]      memAddr,
    output logic [`DATA_WIDTH-1:0]           storeData,
    output logic                             branchTaken,
    output logic                             jumpTaken
);

    opcodeT                      opcode;
    logic [`REG_ADDR_WIDTH-1:0]  rs, rt, rd;
    logic [4:0]                  shamt;
    logic [5:0]                  funct;
    logic [15:0]                 imm;

    regDstT   regDst;
    memToRegT memToReg;
    aluOpT    aluClass, aluClassFixed, aluOp;
    logic     regWrite, aluSrc, memWrite, memRead, branch, signExt, jump, condTrue;

    logic [`DATA_WIDTH-1:0] rsData, rtData, extImm, aluB, aluResult, readData, loadWord;

    assign opcode = opcodeT'(instr[31:26]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];

    DatapathController uCtrl (.opCode(opcode), .regDst(regDst), .regWrite(regWrite),
        .aluSrc(aluSrc), .memWrite(memWrite), .memRead(memRead), .branch(branch),
        .memToReg(memToReg), .signExt(signExt), .jump(jump), .aluClass(aluClass));

    // REGIMM: rt bit 0 set is BGEZ, clear is BLTZ
    assign aluClassFixed = (opcode == OP_REGIMM) ? (rt[0] ? ALU_GEZ : ALU_LTZ) : aluClass;

    AluController uAluCtrl (.aluClass(aluClassFixed), .funct(funct), .aluOp(aluOp));

    RegisterFile uRegs (.clk(clk), .arstN(arstN), .readAddrA(rs), .readAddrB(rt),
        .writeEn(regWriteEn), .writeAddr(writeReg), .writeData(writeData),
        .readDataA(rsData), .readDataB(rtData));

    assign extImm = signExt ? {{(`DATA_WIDTH-16){imm[15]}}, imm} : {{(`DATA_WIDTH-16){1'b0}}, imm};
    assign aluB   = aluSrc ? extImm : rtData; // Immediate or rt operand

    Alu uAlu (.a(rsData), .b(aluB), .shamt(shamt), .aluOp(aluOp), .result(aluResult),
        .condTrue(condTrue));

    DataMemory uDmem (.clk(clk), .arstN(arstN), .addr(memAddr), .writeEn(memWriteEn),
        .writeData(storeData), .readData(readData));

    assign memAddr   = aluResult[`DMEM_ADDR_WIDTH+1:2]; // Byte address to word index
    assign storeData = rtData;
    assign loadWord  = memRead ? readData : '0;

    assign writeReg  = (regDst == DST_RD) ? rd : rt;
    assign writeData = (memToReg == WB_MEM) ? loadWord : aluResult;

    assign regWriteEn  = regWrite & instrValid; // Nothing commits without the strobe
    assign memWriteEn  = memWrite & instrValid;
    assign branchTaken = branch & condTrue & instrValid;
    assign jumpTaken   = jump & instrValid;

endmodule

`default_nettype wire

//--- verification/ExecuteCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module ExecuteCoreTb;

    localparam int NUM_CASES  = 33; // Lines in core_cases.mem
    localparam int NUM_RAND   = 12;
    localparam int TIMEOUT_NS = (NUM_CASES + NUM_RAND + 20) * 10 * 4;

    logic        clk;
    logic        arstN;
    logic [31:0] instr;
    logic        instrValid;
    logic        regWriteEn;
    logic        memWriteEn;
    logic        branchTaken;
    logic        jumpTaken;
    logic [4:0]  writeReg;
    logic [5:0]  memAddr;
    logic [31:0] writeData;
    logic [31:0] storeData;

    logic [31:0] caseMem [NUM_CASES*4]; // Four words per case
    logic [31:0] lcgState;
    int          errorCount;
    int          testCount;
    int          caseErrors;

    ExecuteCore UUT (.clk(clk), .arstN(arstN), .instr(instr), .instrValid(instrValid),
        .regWriteEn(regWriteEn), .writeReg(writeReg), .writeData(writeData),
        .memWriteEn(memWriteEn), .memAddr(memAddr), .storeData(storeData),
        .branchTaken(branchTaken), .jumpTaken(jumpTaken));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    // Expected R-type results for the random cases
    function automatic logic [31:0] expectRtype(input logic [5:0] fn, input logic [31:0] a,
                                                input logic [31:0] b);
        case (fn)
            6'h21:   return a + b;
            6'h22:   return a - b;
            6'h2a:   return {31'b0, $signed(a) < $signed(b)};
            default: return {31'b0, a < b}; // SLTU
        endcase
    endfunction

    task automatic checkValue(input string sig, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
            else begin
                $display("[FAIL] test %0d %s: expected %h, got %h", testCount, sig, exp, got);
                caseErrors++;
            end
    endtask

    // Drive one instruction, sample 1 ns before the commit edge
    task automatic runInstr(input logic [31:0] word, input logic [3:0] expFlags,
                            input logic [5:0] expReg, input logic [31:0] expData,
                            input logic valid);
        caseErrors = 0;
        testCount++;
        @(posedge clk);
        instr      <= word;
        instrValid <= valid;
        #9;
        checkValue("{regWriteEn,memWriteEn,branchTaken,jumpTaken}",
            {28'b0, regWriteEn, memWriteEn, branchTaken, jumpTaken}, {28'b0, expFlags});
        if (expFlags[3]) begin
            checkValue("writeReg", {27'b0, writeReg}, {27'b0, expReg[4:0]});
            checkValue("writeData", writeData, expData);
        end
        if (expFlags[2]) begin
            checkValue("memAddr", {26'b0, memAddr}, {26'b0, expReg});
            checkValue("storeData", storeData, expData);
        end
        errorCount += caseErrors;
        $display("test %0d instr %h: %s", testCount, word, (caseErrors == 0) ? "ok" : "mismatch");
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] valA;
        logic [31:0] valB;
        logic [5:0]  fn;
        logic [23:0] functList;

        functList  = {6'h21, 6'h22, 6'h2a, 6'h2b}; // ADDU SUB SLT SLTU
        errorCount = 0;
        testCount  = 0;
        caseErrors = 0;
        lcgState   = 32'd18378;
        arstN      = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        $readmemh("verification/core_cases.mem", caseMem);

        repeat (5) @(posedge clk);
        arstN <= 1'b1;

        // Strobe low, so the ADDIU must not commit
        runInstr(32'h24017fff, 4'h0, 6'h00, 32'h0, 1'b0);
        // ADDU r3, r1, r2 reads the untouched r1 and r2
        runInstr(32'h00221821, 4'h8, 6'h03, 32'h0, 1'b1);

        for (int i = 0; i < NUM_CASES; i++) begin
            runInstr(caseMem[4*i], caseMem[4*i+1][3:0], caseMem[4*i+2][5:0],
                caseMem[4*i+3], 1'b1);
        end

        // Random operands loaded into r25 and r26 through ADDIU
        for (int r = 0; r < 2; r++) begin
            rnd  = nextRandom();
            valA = {{16{rnd[31]}}, rnd[31:16]};
            rnd  = nextRandom();
            valB = {{16{rnd[31]}}, rnd[31:16]};
            runInstr({6'h09, 5'd0, 5'd25, valA[15:0]}, 4'h8, 6'd25, valA, 1'b1);
            runInstr({6'h09, 5'd0, 5'd26, valB[15:0]}, 4'h8, 6'd26, valB, 1'b1);
            for (int k = 0; k < 4; k++) begin
                fn = functList[23-6*k -: 6];
                runInstr({6'h00, 5'd25, 5'd26, 5'd27, 5'd0, fn}, 4'h8, 6'd27,
                    expectRtype(fn, valA, valB), 1'b1);
            end
        end

        @(posedge clk);
        instrValid <= 1'b0;
        $display("%0d tests run, %0d failed checks", testCount, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/core_cases.mem
// Columns: instr, flags {regWriteEn,memWriteEn,branchTaken,jumpTaken},
// writeReg (memAddr for a store), writeData (storeData for a store)
00001821 8 03 00000000 // ADDU r3, r0, r0
24017fff 8 01 00007fff // ADDIU r1, r0, 0x7fff
2402ffff 8 02 ffffffff // ADDIU r2, r0, -1
00222021 8 04 00007ffe // ADDU r4, r1, r2
20450001 8 05 00000000 // ADDI r5, r2, 1
00223022 8 06 00008000 // SUB r6, r1, r2
0041382a 8 07 00000001 // SLT r7, r2, r1
0041402b 8 08 00000000 // SLTU r8, r2, r1
28490000 8 09 00000001 // SLTI r9, r2, 0
304b8f0f 8 0b 00008f0f // ANDI r11, r2, 0x8f0f
340c8000 8 0c 00008000 // ORI r12, r0, 0x8000
384d00ff 8 0d ffffff00 // XORI r13, r2, 0xff
00208827 8 11 ffff8000 // NOR r17, r1, r0
00019100 8 12 0007fff0 // SLL r18, r1, 4
00029a02 8 13 00ffffff // SRL r19, r2, 8
ac010024 4 09 00007fff // SW r1, 0x24(r0)
8d340023 8 14 00007fff // LW r20, 0x23(r9)
10210010 2 00 00000000 // BEQ r1, r1
10220010 0 00 00000000 // BEQ r1, r2
14220010 2 00 00000000 // BNE r1, r2
14050010 0 00 00000000 // BNE r0, r5
18a00010 2 00 00000000 // BLEZ r5
18200010 0 00 00000000 // BLEZ r1
1c200010 2 00 00000000 // BGTZ r1
1c400010 0 00 00000000 // BGTZ r2
04010010 2 00 00000000 // BGEZ r0
04410010 0 00 00000000 // BGEZ r2
04400010 2 00 00000000 // BLTZ r2
04200010 0 00 00000000 // BLTZ r1
08000040 1 00 00000000 // J
24001234 8 00 00001234 // ADDIU r0, r0, 0x1234
0000b021 8 16 00000000 // ADDU r22, r0, r0
80170000 0 00 00000000 // LB r23, 0(r0)

//--- verilog.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/DatapathController.sv
rtl/AluController.sv
rtl/Alu.sv
rtl/RegisterFile.sv
rtl/DataMemory.sv
rtl/ExecuteCore.sv
verification/ExecuteCoreTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module ExecuteCoreTb &&
./obj_dir/VExecuteCoreTb | tee /dev/stderr | grep -q "Regression passed" &&
echo "simulation PASS" || { echo "simulation FAIL"; exit 1; }
